// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_tag_array.sv
      - rtl/dcache_data_array.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache.sv
  - target: test
    files:
      - tb/dcache_mem_model.sv
      - tb/tb_dcache.sv

// File: rtl/dcache.sv
/*
    two-way set-associative write-back data cache
    - controller, tag array and data array
    - datapath load/store port and single-word memory port
*/
`timescale 1ns/1ns

module dcache
    import dcache_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_addr_u      dmem_addr,
    input  logic [WORD_W-1:0] dmem_store,
    input  logic              halt,
    output logic [WORD_W-1:0] dmem_load,
    output logic              dhit,
    output logic              flushed,
    output logic              dren,
    output logic              dwen,
    output dcache_addr_u      daddr,
    output logic [WORD_W-1:0] dstore,
    input  logic [WORD_W-1:0] dload,
    input  logic              dwait
);

    logic                hit, victim_valid, victim_dirty, flush_valid, flush_dirty;
    way_t                hit_way, victim_way, fill_way, word_way, mem_word_way;
    logic [TAG_W-1:0]    victim_tag, flush_tag;
    logic                fill_en, wb_done, flush_clear, lookup_sel, write_hit;
    logic [IDX_W-1:0]    flush_idx, mem_word_idx;
    logic                word_we, word_data_sel;
    logic [BLKOFF_W-1:0] word_sel, mem_word_sel;

    dcache_ctrl i_ctrl (
        .CLK, .nRST, .dmem_ren, .dmem_wen, .halt,
        .req_addr      (dmem_addr),
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag,
        .flush_valid, .flush_dirty, .flush_tag, .dwait,
        .dhit, .flushed, .dren, .dwen, .daddr,
        .fill_en, .fill_way, .wb_done, .flush_clear, .flush_idx, .lookup_sel,
        .write_hit, .word_we, .word_way, .word_sel, .word_data_sel,
        .mem_word_idx, .mem_word_way, .mem_word_sel
    );

    dcache_tag_array i_tags (
        .CLK, .nRST,
        .req_addr      (dmem_addr),
        .lookup_sel, .flush_idx, .fill_en, .fill_way, .wb_done, .flush_clear,
        .write_hit, .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty,
        .victim_tag, .flush_valid, .flush_dirty, .flush_tag
    );

    dcache_data_array i_data (
        .CLK, .nRST,
        .rd_addr       (dmem_addr),
        .hit_way, .word_we, .word_way, .word_sel, .word_data_sel,
        .store_data    (dmem_store),
        .load_data     (dload),
        .dmem_load, .mem_word_idx, .mem_word_way, .mem_word_sel, .dstore
    );

endmodule

// File: rtl/dcache_ctrl.sv
/*
    data cache controller
    - state register and flush walk counter
    - hit detect, miss fill and dirty victim write-back
    - memory port address and strobes
    - tag and data array control
*/
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmem_ren,
    input  logic                dmem_wen,
    input  logic                halt,
    input  dcache_addr_u        req_addr,
    input  logic                hit,
    input  way_t                hit_way,
    input  way_t                victim_way,
    input  logic                victim_valid,
    input  logic                victim_dirty,
    input  logic [TAG_W-1:0]    victim_tag,
    input  logic                flush_valid,
    input  logic                flush_dirty,
    input  logic [TAG_W-1:0]    flush_tag,
    input  logic                dwait,
    output logic                dhit,
    output logic                flushed,
    output logic                dren,
    output logic                dwen,
    output dcache_addr_u        daddr,
    output logic                fill_en,
    output way_t                fill_way,
    output logic                wb_done,
    output logic                flush_clear,
    output logic [IDX_W-1:0]    flush_idx,
    output logic                lookup_sel,
    output logic                write_hit,
    output logic                word_we,
    output way_t                word_way,
    output logic [BLKOFF_W-1:0] word_sel,
    output logic                word_data_sel,
    output logic [IDX_W-1:0]    mem_word_idx,
    output way_t                mem_word_way,
    output logic [BLKOFF_W-1:0] mem_word_sel
);

    dcache_state_e    state, next_state;
    logic [IDX_W:0]   flush_cnt; // {set, way}
    logic             req;
    logic             flushing;
    way_t             flush_way;

    assign req       = dmem_ren || dmem_wen;
    assign flushing  = state inside {FLUSH_W1, FLUSH_W2, FLUSH_DONE};
    assign flush_idx = flush_cnt[IDX_W:1];
    assign flush_way = way_t'(flush_cnt[0]);

    assign lookup_sel = flushing || !req;
    assign dhit       = (state == IDLE) && req && hit;
    assign write_hit  = dhit && dmem_wen;
    assign flushed    = (state == FLUSH_DONE);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE) begin
                flush_cnt <= '0;
            end else if (flush_clear) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state    = state;
        dren          = 1'b0;
        dwen          = 1'b0;
        daddr.raw     = '0;
        fill_en       = 1'b0;
        wb_done       = 1'b0;
        flush_clear   = 1'b0;
        fill_way      = flushing ? flush_way : victim_way;
        word_we       = 1'b0;
        word_way      = victim_way;
        word_sel      = '0;
        word_data_sel = 1'b1;
        mem_word_idx  = flushing ? flush_idx : req_addr.f.idx;
        mem_word_way  = flushing ? flush_way : victim_way;
        mem_word_sel  = '0;

        case (state)
            IDLE: begin
                if (req && hit) begin
                    word_we       = write_hit;
                    word_way      = hit_way;
                    word_sel      = req_addr.f.blkoff;
                    word_data_sel = 1'b0;
                end else if (req) begin
                    next_state = (victim_valid && victim_dirty) ? WB1 : FETCH1;
                end else if (halt) begin
                    next_state = FLUSH_W1;
                end
            end
            WB1, WB2: begin
                dwen          = 1'b1;
                mem_word_sel  = (state == WB2);
                daddr.f.tag   = victim_tag;
                daddr.f.idx   = req_addr.f.idx;
                daddr.f.blkoff = mem_word_sel;
                if (!dwait) begin
                    wb_done    = (state == WB2); // victim now clean
                    next_state = (state == WB1) ? WB2 : FETCH1;
                end
            end
            FETCH1, FETCH2: begin
                dren           = 1'b1;
                word_sel       = (state == FETCH2);
                daddr.f.tag    = req_addr.f.tag;
                daddr.f.idx    = req_addr.f.idx;
                daddr.f.blkoff = word_sel;
                if (!dwait) begin
                    word_we    = 1'b1;
                    fill_en    = (state == FETCH2);
                    next_state = (state == FETCH1) ? FETCH2 : IDLE;
                end
            end
            FLUSH_W1, FLUSH_W2: begin
                mem_word_sel   = (state == FLUSH_W2);
                daddr.f.tag    = flush_tag;
                daddr.f.idx    = flush_idx;
                daddr.f.blkoff = mem_word_sel;
                if (state == FLUSH_W1 && !(flush_valid && flush_dirty)) begin
                    flush_clear = 1'b1; // clean block skipped
                end else begin
                    dwen = 1'b1;
                    if (!dwait) begin
                        flush_clear = (state == FLUSH_W2);
                        next_state  = FLUSH_W2;
                    end
                end
                if (flush_clear) begin
                    next_state = (&flush_cnt) ? FLUSH_DONE : FLUSH_W1;
                end
            end
            FLUSH_DONE: begin
                next_state = FLUSH_DONE; // held until reset
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    mem_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
        (dren || dwen) && dwait |=> $stable(daddr) && $stable(dren) && $stable(dwen))
        else $error("memory request changed while dwait was high");

    // the held request must hit once its block is installed
    fill_then_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (state == FETCH2) && !dwait |=> dhit)
        else $error("no hit after a block fill");

endmodule

// File: rtl/dcache_data_array.sv
/*
    word storage of the data cache
    - two words per way per set
    - read port for the datapath load
    - read port for the memory store word
*/
`timescale 1ns/1ns

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  dcache_addr_u        rd_addr,
    input  way_t                hit_way,
    input  logic                word_we,
    input  way_t                word_way,
    input  logic [BLKOFF_W-1:0] word_sel,
    input  logic                word_data_sel, // 0 store word, 1 memory load
    input  logic [WORD_W-1:0]   store_data,
    input  logic [WORD_W-1:0]   load_data,
    output logic [WORD_W-1:0]   dmem_load,
    input  logic [IDX_W-1:0]    mem_word_idx,
    input  way_t                mem_word_way,
    input  logic [BLKOFF_W-1:0] mem_word_sel,
    output logic [WORD_W-1:0]   dstore
);

    logic [WORD_W-1:0] words [NUM_SETS][NUM_WAYS][BLK_WORDS];
    logic [WORD_W-1:0] wr_data;

    assign wr_data = word_data_sel ? load_data : store_data;

    // writes always land in the set of the pending request
    always_ff @(posedge CLK) begin
        if (word_we) begin
            words[rd_addr.f.idx][word_way][word_sel] <= wr_data;
        end
    end

    assign dmem_load = words[rd_addr.f.idx][hit_way][rd_addr.f.blkoff];
    assign dstore    = words[mem_word_idx][mem_word_way][mem_word_sel];

    // a store is visible to an unchanged request one cycle later
    store_then_load: assert property (@(posedge CLK) disable iff (!nRST)
        (word_we && !word_data_sel) ##1 ($stable(rd_addr) && hit_way == $past(word_way))
        |-> dmem_load == $past(store_data))
        else $error("stored word not returned on reread");

endmodule

// File: rtl/dcache_pkg.sv
/*
    data cache shared definitions
    - geometry localparams (8 sets, 2 ways, 2 words per block)
    - address word with raw and field views
    - way select type
    - controller state encoding
*/
package dcache_pkg;

    localparam int WORD_W    = 32;
    localparam int NUM_SETS  = 8;
    localparam int NUM_WAYS  = 2;
    localparam int IDX_W     = 3;
    localparam int BLK_WORDS = 2;
    localparam int BYTE_W    = 2;
    localparam int BLKOFF_W  = $clog2(BLK_WORDS);
    localparam int TAG_W     = WORD_W - IDX_W - BLKOFF_W - BYTE_W; // 26

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [IDX_W-1:0]    idx;
        logic [BLKOFF_W-1:0] blkoff;
        logic [BYTE_W-1:0]   byteoff;
    } dcache_fields_t;

    // one address word, seen either whole or split into cache fields
    typedef union packed {
        logic [WORD_W-1:0] raw;
        dcache_fields_t    f;
    } dcache_addr_u;

    typedef logic way_t;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        FETCH1,
        FETCH2,
        FLUSH_W1,
        FLUSH_W2,
        FLUSH_DONE
    } dcache_state_e;

endpackage

// File: rtl/dcache_tag_array.sv
/*
    tag store of the data cache
    - tag, valid, dirty per way and one LRU bit per set
    - hit compare of the request tag against both ways
    - victim and flush block status
*/
`timescale 1ns/1ns

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  dcache_addr_u       req_addr,
    input  logic               lookup_sel,   // 0 request index, 1 flush index
    input  logic [IDX_W-1:0]   flush_idx,
    input  logic               fill_en,
    input  way_t               fill_way,
    input  logic               wb_done,
    input  logic               flush_clear,
    input  logic               write_hit,
    output logic               hit,
    output way_t               hit_way,
    output way_t               victim_way,
    output logic               victim_valid,
    output logic               victim_dirty,
    output logic [TAG_W-1:0]   victim_tag,
    output logic               flush_valid,
    output logic               flush_dirty,
    output logic [TAG_W-1:0]   flush_tag
);

    logic [TAG_W-1:0]    tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty [NUM_SETS];
    way_t                lru   [NUM_SETS]; // way to evict next
    logic [IDX_W-1:0]    sel_idx;
    logic [NUM_WAYS-1:0] match;

    assign sel_idx  = lookup_sel ? flush_idx : req_addr.f.idx;
    assign match[0] = valid[sel_idx][0] && (tags[sel_idx][0] == req_addr.f.tag);
    assign match[1] = valid[sel_idx][1] && (tags[sel_idx][1] == req_addr.f.tag);

    // flush lookups never report a hit
    assign hit     = !lookup_sel && (|match);
    assign hit_way = way_t'(match[1]);

    assign victim_way   = lru[sel_idx];
    assign victim_valid = valid[sel_idx][victim_way];
    assign victim_dirty = dirty[sel_idx][victim_way];
    assign victim_tag   = tags[sel_idx][victim_way];

    assign flush_valid = valid[flush_idx][fill_way];
    assign flush_dirty = dirty[flush_idx][fill_way];
    assign flush_tag   = tags[flush_idx][fill_way];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            if (hit) begin
                lru[sel_idx] <= ~hit_way;
            end
            if (write_hit) begin
                dirty[sel_idx][hit_way] <= 1'b1;
            end
            if (fill_en) begin
                valid[req_addr.f.idx][fill_way] <= 1'b1;
                dirty[req_addr.f.idx][fill_way] <= 1'b0; // fresh from memory
            end
            if (wb_done) begin
                dirty[req_addr.f.idx][fill_way] <= 1'b0;
            end
            if (flush_clear) begin
                valid[flush_idx][fill_way] <= 1'b0;
                dirty[flush_idx][fill_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_en) begin
            tags[req_addr.f.idx][fill_way] <= req_addr.f.tag;
        end
    end

    // a tag lives in at most one way, so hit_way names the valid match
    hit_way_unique: assert property (@(posedge CLK) disable iff (!nRST)
        hit |-> $onehot(match))
        else $error("request tag valid in both ways");

    // the controller must write back before it refills a way
    fill_not_dirty: assert property (@(posedge CLK) disable iff (!nRST)
        fill_en |-> !dirty[req_addr.f.idx][fill_way])
        else $error("fill over a dirty block");

endmodule

// File: tb/dcache_mem_model.sv
/*
    memory model for the data cache testbench
    - word storage preset from the address
    - random dwait stall of 0 to 3 cycles per word
    - read and write completion counters
    - word peek for end-of-run comparison
*/
`timescale 1ns/1ns

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dren,
    input  logic              dwen,
    input  logic [WORD_W-1:0] daddr,
    input  logic [WORD_W-1:0] dstore,
    output logic [WORD_W-1:0] dload,
    output logic              dwait
);

    logic [WORD_W-1:0] mem [1024];
    logic [1:0]        wait_left; // stall cycles left for this word
    int                rd_count;
    int                wr_count;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i << 2) ^ 32'hA5A50000;
        end
    end

    assign dload = mem[daddr[11:2]];
    assign dwait = (dren || dwen) && (wait_left != 0);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_left <= '0;
            rd_count  <= 0;
            wr_count  <= 0;
        end else if (dren || dwen) begin
            if (wait_left != 0) begin
                wait_left <= wait_left - 1'b1;
            end else begin
                wait_left <= 2'($urandom_range(3, 0)); // stall for the next word
                if (dwen) begin
                    mem[daddr[11:2]] <= dstore;
                    wr_count         <= wr_count + 1;
                end else begin
                    rd_count <= rd_count + 1;
                end
            end
        end
    end

    function automatic logic [WORD_W-1:0] peek_word(input logic [WORD_W-1:0] addr);
        return mem[addr[11:2]];
    endfunction

endmodule

// File: tb/dcache_tests.txt
# op    address  value    mem_reads mem_writes
# value is the store word for write and the expected load for read
read  00000000 a5a50000 2 0
read  00000004 a5a50004 0 0
write 00000004 11110004 0 0
read  00000004 11110004 0 0
read  00000048 a5a50048 2 0
read  00000088 a5a50088 2 0
read  00000048 a5a50048 0 0
read  000000c8 a5a500c8 2 0
read  00000048 a5a50048 0 0
read  00000088 a5a50088 2 0
write 00000040 22220040 2 0
write 00000080 33330080 2 2
read  00000004 11110004 2 2
read  00000040 22220040 2 2
write 0000004c 4444004c 0 0
write 000001f8 555501f8 2 0
read  000001f8 555501f8 0 0
halt  00000000 00000000 0 4

// File: tb/tb_dcache.sv
/*
    testbench for the data cache
    - clock, reset, DUT and memory model
    - test file reader and request driver
    - value checker and flush comparison
*/
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
();

    logic              CLK;
    logic              nRST;
    logic              dmem_ren;
    logic              dmem_wen;
    dcache_addr_u      dmem_addr;
    logic [WORD_W-1:0] dmem_store;
    logic              halt;
    logic [WORD_W-1:0] dmem_load;
    logic              dhit;
    logic              flushed;
    logic              dren;
    logic              dwen;
    dcache_addr_u      daddr;
    logic [WORD_W-1:0] dstore;
    logic [WORD_W-1:0] dload;
    logic              dwait;

    logic [WORD_W-1:0] ref_mem [1024]; // expected memory image
    bit                touched [1024];

    dcache i_dut (.*);

    dcache_mem_model i_mem (
        .CLK, .nRST, .dren, .dwen,
        .daddr (daddr.raw),
        .dstore, .dload, .dwait
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [WORD_W-1:0] actual, input logic [WORD_W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // one load or store, held until dhit, sampled mid low phase
    task automatic run_request(input logic is_write, input logic [WORD_W-1:0] addr,
                               input logic [WORD_W-1:0] value, input int exp_rd, exp_wr);
        int waits;
        int rd_start;
        int wr_start;
        @(negedge CLK);
        rd_start      = i_mem.rd_count;
        wr_start      = i_mem.wr_count;
        dmem_ren      = !is_write;
        dmem_wen      = is_write;
        dmem_addr.raw = addr;
        dmem_store    = is_write ? value : '0;
        waits         = 0;
        #10;
        while (!dhit) begin
            if (waits >= 100) begin
                abort_run($sformatf("Timeout: no dhit for address %h", addr));
            end
            @(negedge CLK);
            #10;
            waits++;
        end
        if (!is_write) begin
            check_value(dmem_load, value, $sformatf("load from %h", addr));
            check_value(dmem_load, ref_mem[addr[11:2]], $sformatf("reference at %h", addr));
        end
        check_value(i_mem.rd_count - rd_start, exp_rd, "memory reads");
        check_value(i_mem.wr_count - wr_start, exp_wr, "memory writes");
        check_value(waits == 0, exp_rd == 0 && exp_wr == 0, "dhit in request cycle");
        @(posedge CLK);
        if (is_write) begin
            ref_mem[addr[11:2]] = value;
        end
        touched[addr[11:2]] = 1'b1;
    endtask

    task automatic halt_and_compare(input int exp_wr);
        int waits;
        int wr_start;
        @(negedge CLK);
        wr_start = i_mem.wr_count;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        halt     = 1'b1;
        waits    = 0;
        #10;
        while (!flushed) begin
            if (waits >= 500) begin
                abort_run("Timeout: flushed never rose after halt");
            end
            @(negedge CLK);
            #10;
            waits++;
        end
        check_value(i_mem.wr_count - wr_start, exp_wr, "flush memory writes");
        for (int i = 0; i < 1024; i++) begin
            if (touched[i]) begin
                check_value(i_mem.peek_word(i << 2), ref_mem[i],
                            $sformatf("memory word %h after flush", i << 2));
            end
        end
    endtask

    initial begin
        int                fd;
        int                fields;
        int                seed_draw;
        int                exp_rd;
        int                exp_wr;
        string             line;
        string             op;
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] value;
        seed_draw     = $urandom(84);
        nRST          = 1'b0;
        dmem_ren      = 1'b0;
        dmem_wen      = 1'b0;
        dmem_addr.raw = '0;
        dmem_store    = '0;
        halt          = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = (i << 2) ^ 32'hA5A50000;
            touched[i] = 1'b0;
        end
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #10;
        check_value(dren, 1'b0, "dren after reset");
        check_value(dwen, 1'b0, "dwen after reset");
        check_value(dhit, 1'b0, "dhit after reset");
        check_value(flushed, 1'b0, "flushed after reset");

        fd = $fopen("tb/dcache_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the test file tb/dcache_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue; // header and blank lines
            fields = $sscanf(line, "%s %h %h %d %d", op, addr, value, exp_rd, exp_wr);
            if (fields != 5) begin
                abort_run($sformatf("Test file line is malformed: %s", line));
            end
            if (op == "read") begin
                run_request(1'b0, addr, value, exp_rd, exp_wr);
            end else if (op == "write") begin
                run_request(1'b1, addr, value, exp_rd, exp_wr);
            end else if (op == "halt") begin
                halt_and_compare(exp_wr);
            end else begin
                abort_run($sformatf("Test file has an unknown operation: %s", op));
            end
        end
        $fclose(fd);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tb/dcache_mem_model.sv
tb/tb_dcache.sv
